//--- list.f
+incdir+tb
src/rv_pkg.sv
src/fetch_stage.sv
src/reg_file.sv
src/decode_stage.sv
src/alu.sv
src/execute_stage.sv
src/rv_core_top.sv
tb/tb_rv_core.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_rv_core -f list.f -o sim_rv_core \
    > build.log 2>&1 && ./obj_dir/sim_rv_core > sim.log 2>&1 || echo "build or run failed"
grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" && exit 0 || exit 1

//--- src/alu.sv
`timescale 1ns/100ps

module alu (
    input  logic [rv_pkg::XLEN-1:0]       i_a,
    input  logic [rv_pkg::XLEN-1:0]       i_b,
    input  logic [rv_pkg::ALU_CODE_W-1:0] i_code,
    output logic [rv_pkg::XLEN-1:0]       o_y
);

    logic [4:0] shamt;

    assign shamt = i_b[4:0]; // only low five bits shift

    always_comb begin
        case (i_code)
            rv_pkg::ALU_ADD: o_y = i_a + i_b;
            rv_pkg::ALU_SUB: o_y = i_a - i_b;
            rv_pkg::ALU_AND: o_y = i_a & i_b;
            rv_pkg::ALU_OR:  o_y = i_a | i_b;
            rv_pkg::ALU_SLT: o_y = {{(rv_pkg::XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
            rv_pkg::ALU_XOR: o_y = i_a ^ i_b;
            rv_pkg::ALU_SLL: o_y = i_a << shamt;
            rv_pkg::ALU_SRA: o_y = $unsigned($signed(i_a) >>> shamt);
            rv_pkg::ALU_SRL: o_y = i_a >> shamt;
            default:         o_y = i_a + i_b;
        endcase
    end

endmodule

//--- src/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::XLEN-1:0]       i_if_pc,
    input  rv_pkg::instr_u                i_if_instr,
    input  logic                          i_flush,
    input  logic                          i_wb_en,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_wb_addr,
    input  logic [rv_pkg::XLEN-1:0]       i_wb_data,
    output logic [rv_pkg::XLEN-1:0]       o_id_pc,
    output logic [rv_pkg::XLEN-1:0]       o_id_imm,
    output logic [rv_pkg::XLEN-1:0]       o_id_rs1_data,
    output logic [rv_pkg::XLEN-1:0]       o_id_rs2_data,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_id_rs1_addr,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_id_rs2_addr,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_id_rd_addr,
    output logic [rv_pkg::ALU_CODE_W-1:0] o_id_alu_code,
    output logic                          o_id_use_imm,
    output logic                          o_id_link,
    output logic                          o_id_regwrite,
    output logic                          o_id_beq,
    output logic                          o_id_bne
);

    logic [rv_pkg::XLEN-1:0]       i_imm;
    logic [rv_pkg::XLEN-1:0]       b_imm;
    logic [rv_pkg::XLEN-1:0]       imm;
    logic [rv_pkg::XLEN-1:0]       rf_rdata1;
    logic [rv_pkg::XLEN-1:0]       rf_rdata2;
    logic [rv_pkg::XLEN-1:0]       rs1_data;
    logic [rv_pkg::XLEN-1:0]       rs2_data;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_pkg::ALU_CODE_W-1:0] alu_code;
    logic                          use_imm;
    logic                          link;
    logic                          regwrite;
    logic                          beq;
    logic                          bne;

    assign rs1 = i_if_instr.r_fmt.rs1;
    assign rs2 = i_if_instr.r_fmt.rs2;

    assign i_imm = {{(rv_pkg::XLEN-12){i_if_instr.i_fmt.imm_11_0[11]}},
                    i_if_instr.i_fmt.imm_11_0};
    assign b_imm = {{(rv_pkg::XLEN-13){i_if_instr.b_fmt.imm_12}}, i_if_instr.b_fmt.imm_12,
                    i_if_instr.b_fmt.imm_11, i_if_instr.b_fmt.imm_10_5,
                    i_if_instr.b_fmt.imm_4_1, 1'b0};

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_wen    (i_wb_en),
        .i_waddr  (i_wb_addr),
        .i_wdata  (i_wb_data),
        .i_raddr1 (rs1),
        .i_raddr2 (rs2),
        .o_rdata1 (rf_rdata1),
        .o_rdata2 (rf_rdata2)
    );

    // write-through: the writeback lands at the same edge we register
    assign rs1_data = (i_wb_en && (i_wb_addr == rs1) && (rs1 != '0)) ? i_wb_data : rf_rdata1;
    assign rs2_data = (i_wb_en && (i_wb_addr == rs2) && (rs2 != '0)) ? i_wb_data : rf_rdata2;

    always_comb begin
        use_imm  = 1'b0;
        link     = 1'b0;
        regwrite = 1'b0;
        beq      = 1'b0;
        bne      = 1'b0;
        imm      = i_imm;
        case (i_if_instr.r_fmt.opcode)
            rv_pkg::OPC_OP: regwrite = 1'b1;
            rv_pkg::OPC_OP_IMM: begin
                regwrite = 1'b1;
                use_imm  = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                imm = b_imm;
                beq = (i_if_instr.b_fmt.funct3 == rv_pkg::F3_BEQ);
                bne = (i_if_instr.b_fmt.funct3 == rv_pkg::F3_BNE);
            end
            rv_pkg::OPC_JAL: begin
                imm      = rv_pkg::j_imm(i_if_instr);
                regwrite = 1'b1;
                link     = 1'b1; // writes pc + 4
            end
            default: ;
        endcase
    end

    // bit 30 picks sub and sra; sub only exists in R-type
    always_comb begin
        case (i_if_instr.r_fmt.funct3)
            rv_pkg::F3_ADD_SUB: alu_code = (i_if_instr.r_fmt.funct7[5] &&
                                            (i_if_instr.r_fmt.opcode == rv_pkg::OPC_OP)) ?
                                           rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            rv_pkg::F3_SLL: alu_code = rv_pkg::ALU_SLL;
            rv_pkg::F3_SLT: alu_code = rv_pkg::ALU_SLT;
            rv_pkg::F3_XOR: alu_code = rv_pkg::ALU_XOR;
            rv_pkg::F3_SR:  alu_code = i_if_instr.r_fmt.funct7[5] ?
                                       rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            rv_pkg::F3_OR:  alu_code = rv_pkg::ALU_OR;
            rv_pkg::F3_AND: alu_code = rv_pkg::ALU_AND;
            default:        alu_code = rv_pkg::ALU_ADD;
        endcase
        if (link) begin
            alu_code = rv_pkg::ALU_ADD;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_id_alu_code <= rv_pkg::ALU_ADD;
            o_id_use_imm  <= 1'b0;
            o_id_link     <= 1'b0;
            o_id_regwrite <= 1'b0;
            o_id_beq      <= 1'b0;
            o_id_bne      <= 1'b0;
        end else if (i_flush) begin
            o_id_alu_code <= rv_pkg::ALU_ADD; // bubble
            o_id_use_imm  <= 1'b0;
            o_id_link     <= 1'b0;
            o_id_regwrite <= 1'b0;
            o_id_beq      <= 1'b0;
            o_id_bne      <= 1'b0;
        end else begin
            o_id_alu_code <= alu_code;
            o_id_use_imm  <= use_imm;
            o_id_link     <= link;
            o_id_regwrite <= regwrite;
            o_id_beq      <= beq;
            o_id_bne      <= bne;
        end
    end

    always_ff @(posedge clk) begin
        o_id_pc       <= i_if_pc;
        o_id_imm      <= imm;
        o_id_rs1_data <= rs1_data;
        o_id_rs2_data <= rs2_data;
        o_id_rs1_addr <= rs1;
        o_id_rs2_addr <= rs2;
        o_id_rd_addr  <= i_if_instr.r_fmt.rd;
    end

endmodule

//--- src/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::XLEN-1:0]       i_pc,
    input  logic [rv_pkg::XLEN-1:0]       i_imm,
    input  logic [rv_pkg::XLEN-1:0]       i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0]       i_rs2_data,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs2_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd_addr,
    input  logic [rv_pkg::ALU_CODE_W-1:0] i_alu_code,
    input  logic                          i_use_imm,
    input  logic                          i_link,
    input  logic                          i_regwrite,
    input  logic                          i_beq,
    input  logic                          i_bne,
    output logic                          o_redirect,
    output logic [rv_pkg::XLEN-1:0]       o_redirect_pc,
    output logic                          o_wb_en,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_wb_addr,
    output logic [rv_pkg::XLEN-1:0]       o_wb_data
);

    logic [rv_pkg::XLEN-1:0] rs1_val;
    logic [rv_pkg::XLEN-1:0] rs2_val;
    logic [rv_pkg::XLEN-1:0] alu_a;
    logic [rv_pkg::XLEN-1:0] alu_b;
    logic [rv_pkg::XLEN-1:0] alu_y;
    logic                    rs_equal;

    // forward from the instruction one ahead, still in the wb register
    assign rs1_val = (o_wb_en && (o_wb_addr == i_rs1_addr) && (i_rs1_addr != '0)) ?
                     o_wb_data : i_rs1_data;
    assign rs2_val = (o_wb_en && (o_wb_addr == i_rs2_addr) && (i_rs2_addr != '0)) ?
                     o_wb_data : i_rs2_data;

    always_comb begin
        if (i_link) begin
            alu_a = rv_pkg::PC_STEP; // link value pc + 4
            alu_b = i_pc;
        end else begin
            alu_a = rs1_val;
            alu_b = i_use_imm ? i_imm : rs2_val;
        end
    end

    alu u_alu (
        .i_a    (alu_a),
        .i_b    (alu_b),
        .i_code (i_alu_code),
        .o_y    (alu_y)
    );

    assign rs_equal      = (rs1_val == rs2_val);
    assign o_redirect    = (i_beq && rs_equal) || (i_bne && !rs_equal);
    assign o_redirect_pc = i_pc + i_imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_wb_en <= 1'b0;
        end else begin
            o_wb_en <= i_regwrite && (i_rd_addr != '0); // x0 targets never write
        end
    end

    always_ff @(posedge clk) begin
        o_wb_addr <= i_rd_addr;
        o_wb_data <= alu_y;
    end

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [rv_pkg::XLEN-1:0] i_imem_rdata,
    input  logic                    i_redirect,
    input  logic [rv_pkg::XLEN-1:0] i_redirect_pc,
    output logic [rv_pkg::XLEN-3:0] o_imem_addr,
    output logic [rv_pkg::XLEN-1:0] o_pc,
    output logic [rv_pkg::XLEN-1:0] o_if_pc,
    output rv_pkg::instr_u          o_if_instr
);

    rv_pkg::instr_u          fetched;
    logic                    is_jal;
    logic [rv_pkg::XLEN-1:0] pc_next;

    // memory returns the word with bytes reversed
    assign fetched = {i_imem_rdata[7:0], i_imem_rdata[15:8],
                      i_imem_rdata[23:16], i_imem_rdata[31:24]};

    assign is_jal      = (fetched.j_fmt.opcode == rv_pkg::OPC_JAL);
    assign o_imem_addr = o_pc[rv_pkg::XLEN-1:2]; // word address

    always_comb begin
        if (i_redirect) begin
            pc_next = i_redirect_pc; // branch in execute wins over jal here
        end else if (is_jal) begin
            pc_next = o_pc + rv_pkg::j_imm(fetched); // jump without a bubble
        end else begin
            pc_next = o_pc + rv_pkg::PC_STEP;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_pc       <= '0;
            o_if_instr <= rv_pkg::NOP_INSTR;
        end else begin
            o_pc       <= pc_next;
            o_if_instr <= i_redirect ? rv_pkg::NOP_INSTR : fetched; // squash wrong path
        end
    end

    always_ff @(posedge clk) begin
        o_if_pc <= o_pc;
    end

endmodule

//--- src/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_wen,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_waddr,
    input  logic [rv_pkg::XLEN-1:0]       i_wdata,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_raddr1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_raddr2,
    output logic [rv_pkg::XLEN-1:0]       o_rdata1,
    output logic [rv_pkg::XLEN-1:0]       o_rdata2
);

    logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS];

    assign o_rdata1 = regs[i_raddr1];
    assign o_rdata2 = regs[i_raddr2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wen && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata; // x0 stays zero
        end
    end

endmodule

//--- src/rv_core_top.sv
`timescale 1ns/100ps

module rv_core_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::XLEN-1:0]       i_imem_rdata,
    output logic [rv_pkg::XLEN-3:0]       o_imem_addr,
    output logic [rv_pkg::XLEN-1:0]       o_pc,
    output logic                          o_wb_en,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_wb_addr,
    output logic [rv_pkg::XLEN-1:0]       o_wb_data
);

    // fetch to decode
    logic [rv_pkg::XLEN-1:0]       if_pc;
    rv_pkg::instr_u                if_instr;

    // decode to execute
    logic [rv_pkg::XLEN-1:0]       id_pc;
    logic [rv_pkg::XLEN-1:0]       id_imm;
    logic [rv_pkg::XLEN-1:0]       id_rs1_data;
    logic [rv_pkg::XLEN-1:0]       id_rs2_data;
    logic [rv_pkg::REG_ADDR_W-1:0] id_rs1_addr;
    logic [rv_pkg::REG_ADDR_W-1:0] id_rs2_addr;
    logic [rv_pkg::REG_ADDR_W-1:0] id_rd_addr;
    logic [rv_pkg::ALU_CODE_W-1:0] id_alu_code;
    logic                          id_use_imm;
    logic                          id_link;
    logic                          id_regwrite;
    logic                          id_beq;
    logic                          id_bne;

    logic                          redirect;
    logic [rv_pkg::XLEN-1:0]       redirect_pc;

    fetch_stage u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_imem_rdata  (i_imem_rdata),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .o_imem_addr   (o_imem_addr),
        .o_pc          (o_pc),
        .o_if_pc       (if_pc),
        .o_if_instr    (if_instr)
    );

    decode_stage u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_if_pc       (if_pc),
        .i_if_instr    (if_instr),
        .i_flush       (redirect),
        .i_wb_en       (o_wb_en),
        .i_wb_addr     (o_wb_addr),
        .i_wb_data     (o_wb_data),
        .o_id_pc       (id_pc),
        .o_id_imm      (id_imm),
        .o_id_rs1_data (id_rs1_data),
        .o_id_rs2_data (id_rs2_data),
        .o_id_rs1_addr (id_rs1_addr),
        .o_id_rs2_addr (id_rs2_addr),
        .o_id_rd_addr  (id_rd_addr),
        .o_id_alu_code (id_alu_code),
        .o_id_use_imm  (id_use_imm),
        .o_id_link     (id_link),
        .o_id_regwrite (id_regwrite),
        .o_id_beq      (id_beq),
        .o_id_bne      (id_bne)
    );

    // writeback signals double as the trace port
    execute_stage u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_pc          (id_pc),
        .i_imm         (id_imm),
        .i_rs1_data    (id_rs1_data),
        .i_rs2_data    (id_rs2_data),
        .i_rs1_addr    (id_rs1_addr),
        .i_rs2_addr    (id_rs2_addr),
        .i_rd_addr     (id_rd_addr),
        .i_alu_code    (id_alu_code),
        .i_use_imm     (id_use_imm),
        .i_link        (id_link),
        .i_regwrite    (id_regwrite),
        .i_beq         (id_beq),
        .i_bne         (id_bne),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc),
        .o_wb_en       (o_wb_en),
        .o_wb_addr     (o_wb_addr),
        .o_wb_data     (o_wb_data)
    );

endmodule

//--- src/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0
    localparam logic [XLEN-1:0] PC_STEP   = 32'd4;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // srl or sra by bit 30
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam int ALU_CODE_W = 4;

    localparam logic [ALU_CODE_W-1:0] ALU_ADD = 4'b0000;
    localparam logic [ALU_CODE_W-1:0] ALU_SUB = 4'b0001;
    localparam logic [ALU_CODE_W-1:0] ALU_AND = 4'b0010;
    localparam logic [ALU_CODE_W-1:0] ALU_OR  = 4'b0011;
    localparam logic [ALU_CODE_W-1:0] ALU_SLT = 4'b0100;
    localparam logic [ALU_CODE_W-1:0] ALU_XOR = 4'b0101;
    localparam logic [ALU_CODE_W-1:0] ALU_SLL = 4'b0110;
    localparam logic [ALU_CODE_W-1:0] ALU_SRA = 4'b0111;
    localparam logic [ALU_CODE_W-1:0] ALU_SRL = 4'b1000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // branch offset is scattered over both ends of the word
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    // jal offset, needed by fetch for the target and by decode for the imm field
    function automatic logic [XLEN-1:0] j_imm(input instr_u w);
        return {{(XLEN-21){w.j_fmt.imm_20}}, w.j_fmt.imm_20, w.j_fmt.imm_19_12,
                w.j_fmt.imm_11, w.j_fmt.imm_10_1, 1'b0};
    endfunction

endpackage

//--- tb/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int PROG_LEN = 33;

// instruction words in normal RISC-V bit order
localparam logic [31:0] PROG_WORDS [PROG_LEN] = '{
    32'h00500093, // 0  addi x1, x0, 5
    32'hFFD00113, // 1  addi x2, x0, -3
    32'h00112193, // 2  slti x3, x2, 1
    32'hFFF0C213, // 3  xori x4, x1, -1
    32'h0F017293, // 4  andi x5, x2, 0xf0
    32'h1000E313, // 5  ori  x6, x1, 0x100
    32'h00409393, // 6  slli x7, x1, 4
    32'h01C15413, // 7  srli x8, x2, 28
    32'h40115493, // 8  srai x9, x2, 1
    32'h00208533, // 9  add  x10, x1, x2
    32'h401505B3, // 10 sub  x11, x10, x1
    32'h00A59633, // 11 sll  x12, x11, x10
    32'h00B626B3, // 12 slt  x13, x12, x11
    32'h00C6C733, // 13 xor  x14, x13, x12
    32'h00D757B3, // 14 srl  x15, x14, x13
    32'h40A75833, // 15 sra  x16, x14, x10
    32'h007868B3, // 16 or   x17, x16, x7
    32'h0068F933, // 17 and  x18, x17, x6
    32'h00108663, // 18 beq  x1, x1, +12   taken
    32'h00100A13, // 19 addi x20, x0, 1    squashed
    32'h00100A93, // 20 addi x21, x0, 1    squashed
    32'h00209663, // 21 bne  x1, x2, +12   taken
    32'h00200A13, // 22 addi x20, x0, 2    squashed
    32'h00200A93, // 23 addi x21, x0, 2    squashed
    32'h00208463, // 24 beq  x1, x2, +8    falls through
    32'h00109463, // 25 bne  x1, x1, +8    falls through
    32'h00700B13, // 26 addi x22, x0, 7
    32'h00C00BEF, // 27 jal  x23, +12
    32'h00100C13, // 28 addi x24, x0, 1    jumped over
    32'h00200C13, // 29 addi x24, x0, 2    jumped over
    32'h001B8C93, // 30 addi x25, x23, 1
    32'h00908013, // 31 addi x0, x1, 9     no write
    32'h00100D33  // 32 add  x26, x0, x1
};

localparam int EXP_LEN = 22;

// architectural writebacks in order, with the test each one belongs to
localparam logic [4:0] EXP_ADDR [EXP_LEN] = '{
    5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9,
    5'd10, 5'd11, 5'd12, 5'd13, 5'd14, 5'd15, 5'd16, 5'd17, 5'd18,
    5'd22, 5'd23, 5'd25, 5'd26
};

localparam logic [31:0] EXP_DATA [EXP_LEN] = '{
    32'h00000005, 32'hFFFFFFFD, 32'h00000001, 32'hFFFFFFFA, 32'h000000F0,
    32'h00000105, 32'h00000050, 32'h0000000F, 32'hFFFFFFFE,
    32'h00000002, 32'hFFFFFFFD, 32'hFFFFFFF4, 32'h00000001, 32'hFFFFFFF5,
    32'h7FFFFFFA, 32'hFFFFFFFD, 32'hFFFFFFFD, 32'h00000105,
    32'h00000007, 32'h00000070, 32'h00000071, 32'h00000005
};

localparam int EXP_TEST [EXP_LEN] = '{
    1, 1, 1, 1, 1, 1, 1, 1, 1,
    2, 2, 2, 2, 2, 2, 2, 2, 2,
    3, 4, 4, 5
};

`endif

//--- tb/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;

    `include "tb_program.svh"

    localparam int PERIOD         = 20;
    localparam int ROM_DEPTH      = 64;
    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 2 + 20;

    logic        clk;
    logic        rst_n;
    logic [31:0] i_imem_rdata;
    logic [29:0] o_imem_addr;
    logic [31:0] o_pc;
    logic        o_wb_en;
    logic [4:0]  o_wb_addr;
    logic [31:0] o_wb_data;

    logic [31:0] rom [ROM_DEPTH];
    logic [4:0]  mdl_addr [ROM_DEPTH];
    logic [31:0] mdl_data [ROM_DEPTH];
    int          mdl_slot [ROM_DEPTH];
    int          n_model;
    int          wb_idx;
    int          cyc;
    int          last_wb_cyc;
    int          err_total;
    int          test_err [NUM_TESTS];
    int          cur_test;
    logic [4:0]  exp_addr_cur;
    logic [31:0] exp_data_cur;
    int          gap_cur;

    rv_core_top i_rv_core_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_imem_rdata (i_imem_rdata),
        .o_imem_addr  (o_imem_addr),
        .o_pc         (o_pc),
        .o_wb_en      (o_wb_en),
        .o_wb_addr    (o_wb_addr),
        .o_wb_data    (o_wb_data)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic string test_name(input int id);
        case (id)
            0:       return "reset";
            1:       return "i_type";
            2:       return "r_type";
            3:       return "branch";
            4:       return "jal";
            default: return "x0";
        endcase
    endfunction

    // reference ALU by the ISA rules where alt selects sub or sra
    function automatic logic [31:0] isa_op(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // architectural walk of the program with one issue slot per instruction
    task automatic build_model();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic        wr;
        int          slot;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = '0;
        slot = 0;
        steps = 0;
        n_model = 0;
        while ((pc[31:2] < PROG_LEN) && (steps < 4 * PROG_LEN)) begin
            w = PROG_WORDS[pc[31:2]];
            wr = 1'b0;
            res = '0;
            next_pc = pc + 32'd4;
            case (w[6:0])
                7'h13: begin
                    wr = 1'b1;
                    res = isa_op(w[14:12], w[30] && (w[14:12] == 3'd5), regs[w[19:15]],
                                 {{20{w[31]}}, w[31:20]});
                end
                7'h33: begin
                    wr = 1'b1;
                    res = isa_op(w[14:12], w[30], regs[w[19:15]], regs[w[24:20]]);
                end
                7'h63: begin
                    if ((w[12] == 1'b0) == (regs[w[19:15]] == regs[w[24:20]])) begin
                        next_pc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                        slot += 2; // two squashed slots
                    end
                end
                7'h6f: begin
                    wr = 1'b1;
                    res = pc + 32'd4;
                    next_pc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                default: ;
            endcase
            if (wr && (w[11:7] != 5'd0)) begin
                regs[w[11:7]] = res;
                mdl_addr[n_model] = w[11:7];
                mdl_data[n_model] = res;
                mdl_slot[n_model] = slot;
                n_model++;
            end
            slot++;
            steps++;
            pc = next_pc;
        end
    endtask

    assign i_imem_rdata = (o_imem_addr[29:6] == '0) ? rom[o_imem_addr[5:0]]
                                                    : swap_bytes(32'h00000013);

    always_comb begin
        exp_addr_cur = '0;
        exp_data_cur = '0;
        cur_test = 5;
        gap_cur = 1;
        if (wb_idx < n_model) begin
            exp_addr_cur = mdl_addr[wb_idx];
            exp_data_cur = mdl_data[wb_idx];
        end
        if (wb_idx < EXP_LEN) begin
            cur_test = EXP_TEST[wb_idx];
        end
        if ((wb_idx > 0) && (wb_idx < n_model)) begin
            gap_cur = mdl_slot[wb_idx] - mdl_slot[wb_idx - 1];
        end
    end

    // checks sample at the falling edge when all outputs have settled
    a_reset_quiet: assert property (@(negedge clk) (cyc == 0) |->
                                    (!o_wb_en && (o_imem_addr == '0) && (o_pc == '0)))
        else begin
            err_total++;
            test_err[0]++;
            $display({"CHECK FAILED %s expected wb_en 0 addr 0 pc 0 ",
                      "actual wb_en %0b addr %0h pc %08h"},
                     test_name(0), o_wb_en, o_imem_addr, o_pc);
        end

    a_wb_extra: assert property (@(negedge clk) (cyc > 0 && o_wb_en) |-> (wb_idx < n_model))
        else begin
            err_total++;
            $display("writeback to x%0d seen after the whole expected list", o_wb_addr);
        end

    a_wb_value: assert property (@(negedge clk) (o_wb_en && wb_idx < n_model) |->
                                 (o_wb_addr == exp_addr_cur && o_wb_data == exp_data_cur))
        else begin
            err_total++;
            test_err[cur_test]++;
            $display("CHECK FAILED %s expected x%0d=%08h actual x%0d=%08h",
                     test_name(cur_test), exp_addr_cur, exp_data_cur, o_wb_addr, o_wb_data);
        end

    a_wb_gap: assert property (@(negedge clk) (o_wb_en && wb_idx > 0 && wb_idx < n_model) |->
                               (cyc - last_wb_cyc == gap_cur))
        else begin
            err_total++;
            test_err[cur_test]++;
            $display("CHECK FAILED %s expected gap %0d actual gap %0d",
                     test_name(cur_test), gap_cur, cyc - last_wb_cyc);
        end

    a_no_x0: assert property (@(negedge clk) o_wb_en |-> (o_wb_addr != '0))
        else begin
            err_total++;
            test_err[5]++;
            $display("CHECK FAILED %s expected no write to x0 actual write %08h",
                     test_name(5), o_wb_data);
        end

    always @(posedge clk) begin
        if (rst_n) begin
            cyc <= cyc + 1;
            if (o_wb_en) begin
                wb_idx <= wb_idx + 1;
                last_wb_cyc <= cyc;
                if ((wb_idx < EXP_LEN) &&
                    ((wb_idx == EXP_LEN - 1) || (EXP_TEST[wb_idx + 1] != cur_test))) begin
                    $display("test %s done, %0d errors", test_name(cur_test),
                             test_err[cur_test]);
                end
            end
        end
    end

    always @(posedge clk) begin
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, only %0d of %0d writebacks seen",
                     cyc, wb_idx, n_model);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        int n_fail;
        rst_n = 1'b0;
        cyc = 0;
        wb_idx = 0;
        last_wb_cyc = 0;
        err_total = 0;
        n_fail = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            test_err[i] = 0;
        end
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom[i] = swap_bytes((i < PROG_LEN) ? PROG_WORDS[i] : 32'h00000013);
        end
        build_model();
        // the model must agree with the stored list
        assert (n_model == EXP_LEN)
            else begin
                err_total++;
                $display("model produced %0d writebacks, stored list has %0d",
                         n_model, EXP_LEN);
            end
        for (int i = 0; i < EXP_LEN && i < n_model; i++) begin
            assert (mdl_addr[i] == EXP_ADDR[i] && mdl_data[i] == EXP_DATA[i])
                else begin
                    err_total++;
                    $display("CHECK FAILED model entry %0d expected x%0d=%08h actual x%0d=%08h",
                             i, EXP_ADDR[i], EXP_DATA[i], mdl_addr[i], mdl_data[i]);
                end
        end
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;
        @(negedge clk);
        @(negedge clk);
        $display("test %s done, %0d errors", test_name(0), test_err[0]);
        wait (wb_idx >= n_model);
        repeat (6) @(posedge clk); // trailing nops must stay silent
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (test_err[i] != 0) begin
                n_fail++;
            end
        end
        $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
                 NUM_TESTS, NUM_TESTS - n_fail, n_fail, err_total);
        if (err_total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
